// ==== logic/pulse_seq_pkg.sv ====
`default_nettype none

package pulse_seq_pkg;

  localparam int OUT_WIDTH  = 8;   // Number of pulse outputs
  localparam int WAIT_WIDTH = 30;  // WAIT cycle count field

  typedef enum logic [1:0] {
    OP_OUT  = 2'd0,  // Masked merge into outputs
    OP_WAIT = 2'd1,  // Hold outputs for a cycle count
    OP_STOP = 2'd2   // End of program, code 3 also stops
  } seq_op_t;

  typedef struct packed {
    seq_op_t                   op;
    logic [29-2*OUT_WIDTH:0]   reserved;
    logic [OUT_WIDTH-1:0]      mask;
    logic [OUT_WIDTH-1:0]      value;
  } seq_out_fields_t;

  typedef struct packed {
    seq_op_t                   op;
    logic [WAIT_WIDTH-1:0]     count;
  } seq_wait_fields_t;

  // One fetched word, viewed by the opcode in its top bits
  typedef union packed {
    seq_out_fields_t  out_fields;
    seq_wait_fields_t wait_fields;
  } seq_cmd_t;

endpackage

`default_nettype wire

// ==== logic/axi_bram_writer.sv ====
`default_nettype none

module axi_bram_writer
#(
  parameter int AXI_DATA_WIDTH  = 32,
  parameter int AXI_ADDR_WIDTH  = 32,
  parameter int BRAM_ADDR_WIDTH = 10
)
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  output logic [BRAM_ADDR_WIDTH-1:0]  bram_addr,
  output logic [AXI_DATA_WIDTH-1:0]   bram_wrdata,
  output logic [AXI_DATA_WIDTH/8-1:0] bram_we
);

  localparam int ADDR_LSB = $clog2(AXI_DATA_WIDTH/8);  // Byte to word address shift

  logic awready_reg, awready_next;
  logic wready_reg, wready_next;
  logic bvalid_reg, bvalid_next;
  logic beat_valid;

  assign beat_valid = s_axi_awvalid & s_axi_wvalid;  // Address and data together

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awready_reg <= 1'b0;
      wready_reg  <= 1'b0;
      bvalid_reg  <= 1'b0;
    end
    else
    begin
      awready_reg <= awready_next;
      wready_reg  <= wready_next;
      bvalid_reg  <= bvalid_next;
    end
  end

  always_comb
  begin
    awready_next = awready_reg;
    wready_next  = wready_reg;
    bvalid_next  = bvalid_reg;
    if (beat_valid && !awready_reg)
    begin
      awready_next = 1'b1;  // Acknowledge on the next cycle
      wready_next  = 1'b1;
    end
    if (awready_reg)
    begin
      awready_next = 1'b0;  // Single-cycle ready pulse
      wready_next  = 1'b0;
      bvalid_next  = 1'b1;
    end
    if (s_axi_bready && bvalid_reg)
      bvalid_next = 1'b0;  // Response taken
  end

  assign s_axi_awready = awready_reg;
  assign s_axi_wready  = wready_reg;
  assign s_axi_bvalid  = bvalid_reg;
  assign s_axi_bresp   = 2'b00;  // Always OKAY

  assign bram_addr   = s_axi_awaddr[ADDR_LSB +: BRAM_ADDR_WIDTH];
  assign bram_wrdata = s_axi_wdata;
  assign bram_we     = beat_valid ? s_axi_wstrb : '0;

endmodule

`default_nettype wire

// ==== logic/seq_bram.sv ====
`default_nettype none

module seq_bram
#(
  parameter int AXI_DATA_WIDTH  = 32,
  parameter int BRAM_ADDR_WIDTH = 10
)
(
  input  logic                        aclk,
  input  logic [BRAM_ADDR_WIDTH-1:0]  wr_addr,
  input  logic [AXI_DATA_WIDTH-1:0]   wr_data,
  input  logic [AXI_DATA_WIDTH/8-1:0] wr_be,
  input  logic [BRAM_ADDR_WIDTH-1:0]  rd_addr,
  output logic [AXI_DATA_WIDTH-1:0]   rd_data
);

  localparam int DEPTH = 2**BRAM_ADDR_WIDTH;

  logic [AXI_DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge aclk)
  begin
    rd_data <= mem[rd_addr];  // Old word returned on a collision
    for (int lane = 0; lane < AXI_DATA_WIDTH/8; lane++)
    begin
      if (wr_be[lane])
        mem[wr_addr][lane*8 +: 8] <= wr_data[lane*8 +: 8];
    end
  end

endmodule

`default_nettype wire

// ==== logic/seq_decoder.sv ====
`default_nettype none

module seq_decoder
  import pulse_seq_pkg::*;
#(
  parameter int BRAM_ADDR_WIDTH = 10
)
(
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       start,
  input  logic                       advance,
  input  seq_cmd_t                   rd_data,
  output logic [BRAM_ADDR_WIDTH-1:0] rd_addr,
  output logic                       cmd_valid,
  output seq_op_t                    op,
  output logic [OUT_WIDTH-1:0]       out_mask,
  output logic [OUT_WIDTH-1:0]       out_value,
  output logic [WAIT_WIDTH-1:0]      wait_count
);

  logic [BRAM_ADDR_WIDTH-1:0] pc;
  logic                       fetch_pending;  // RAM read in flight
  logic                       running;
  logic                       stop_seen;

  assign running   = fetch_pending | cmd_valid;
  assign stop_seen = cmd_valid & (op == OP_STOP);
  assign rd_addr   = pc;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      pc            <= '0;
      fetch_pending <= 1'b0;
      cmd_valid     <= 1'b0;
    end
    else if (start && !running)
    begin
      pc            <= '0;    // Program always begins at word 0
      fetch_pending <= 1'b1;
    end
    else if (fetch_pending)
    begin
      fetch_pending <= 1'b0;
      cmd_valid     <= 1'b1;  // Word is on rd_data now
    end
    else if (advance)
    begin
      pc            <= pc + 1'b1;
      fetch_pending <= 1'b1;
      cmd_valid     <= 1'b0;
    end
    else if (stop_seen)
      cmd_valid <= 1'b0;      // Sequencer goes idle
  end

  // Opcode picks which view of the word is meaningful
  always_comb
  begin
    op         = OP_STOP;
    out_mask   = '0;
    out_value  = '0;
    wait_count = '0;
    case (rd_data.out_fields.op)
      OP_OUT:
      begin
        op        = OP_OUT;
        out_mask  = rd_data.out_fields.mask;
        out_value = rd_data.out_fields.value;
      end
      OP_WAIT:
      begin
        op         = OP_WAIT;
        wait_count = rd_data.wait_fields.count;
      end
      default: op = OP_STOP;  // Unused code also stops
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/seq_executor.sv ====
`default_nettype none

module seq_executor
  import pulse_seq_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  cmd_valid,
  input  seq_op_t               op,
  input  logic [WAIT_WIDTH-1:0] wait_count,
  output logic                  advance,
  output logic                  apply,
  output logic                  finish
);

  logic                  counting;   // WAIT in progress
  logic [WAIT_WIDTH-1:0] remaining;  // Cycles left after this one
  logic                  is_out;
  logic                  is_wait;
  logic                  wait_done;

  assign is_out  = cmd_valid & (op == OP_OUT);
  assign is_wait = cmd_valid & (op == OP_WAIT);

  // First WAIT cycle looks at the fresh count, later ones at the counter
  assign wait_done = counting ? (remaining == '0) : (wait_count == '0);

  assign apply   = is_out;
  assign finish  = cmd_valid & (op == OP_STOP);
  assign advance = is_out | (is_wait & wait_done);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      counting <= 1'b0;
    else
      counting <= is_wait & ~wait_done;  // Drops with the advance
  end

  always_ff @(posedge aclk)
  begin
    if (is_wait && !counting)
      remaining <= wait_count - 1'b1;  // Unused when the count is zero
    else if (counting && !wait_done)
      remaining <= remaining - 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/seq_output.sv ====
`default_nettype none

module seq_output
  import pulse_seq_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 start,
  input  logic                 apply,
  input  logic                 finish,
  input  logic [OUT_WIDTH-1:0] out_mask,
  input  logic [OUT_WIDTH-1:0] out_value,
  output logic [OUT_WIDTH-1:0] pulse_out,
  output logic                 busy,
  output logic                 done
);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      pulse_out <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      if (apply)
        pulse_out <= (pulse_out & ~out_mask) | (out_value & out_mask);  // Masked bits only
      if (finish)
        busy <= 1'b0;
      else if (start)
        busy <= 1'b1;  // Restart while busy has no effect
      done <= finish;  // One-cycle pulse
    end
  end

endmodule

`default_nettype wire

// ==== logic/pulse_seq_top.sv ====
`default_nettype none

module pulse_seq_top
  import pulse_seq_pkg::*;
#(
  parameter int AXI_DATA_WIDTH  = 32,
  parameter int AXI_ADDR_WIDTH  = 32,
  parameter int BRAM_ADDR_WIDTH = 10
)
(
  input  logic                        aclk,
  input  logic                        aresetn,
  input  logic [AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  input  logic [AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  input  logic                        start,
  output logic [OUT_WIDTH-1:0]        pulse_out,
  output logic                        busy,
  output logic                        done
);

  logic [BRAM_ADDR_WIDTH-1:0]  bram_addr;
  logic [AXI_DATA_WIDTH-1:0]   bram_wrdata;
  logic [AXI_DATA_WIDTH/8-1:0] bram_we;
  logic [BRAM_ADDR_WIDTH-1:0]  rd_addr;
  logic [AXI_DATA_WIDTH-1:0]   rd_data;
  logic                        cmd_valid;
  seq_op_t                     op;
  logic [OUT_WIDTH-1:0]        out_mask;
  logic [OUT_WIDTH-1:0]        out_value;
  logic [WAIT_WIDTH-1:0]       wait_count;
  logic                        advance;
  logic                        apply;
  logic                        finish;

  axi_bram_writer #(
    .AXI_DATA_WIDTH  (AXI_DATA_WIDTH),
    .AXI_ADDR_WIDTH  (AXI_ADDR_WIDTH),
    .BRAM_ADDR_WIDTH (BRAM_ADDR_WIDTH)
  ) u_axi_bram_writer (
    .aclk, .aresetn,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .bram_addr, .bram_wrdata, .bram_we
  );

  seq_bram #(
    .AXI_DATA_WIDTH  (AXI_DATA_WIDTH),
    .BRAM_ADDR_WIDTH (BRAM_ADDR_WIDTH)
  ) u_seq_bram (
    .aclk, .wr_addr(bram_addr), .wr_data(bram_wrdata), .wr_be(bram_we),
    .rd_addr, .rd_data
  );

  seq_decoder #(.BRAM_ADDR_WIDTH(BRAM_ADDR_WIDTH)) u_seq_decoder (
    .aclk, .aresetn, .start, .advance, .rd_data,
    .rd_addr, .cmd_valid, .op, .out_mask, .out_value, .wait_count
  );

  seq_executor u_seq_executor (
    .aclk, .aresetn, .cmd_valid, .op, .wait_count, .advance, .apply, .finish
  );

  seq_output u_seq_output (
    .aclk, .aresetn, .start, .apply, .finish, .out_mask, .out_value,
    .pulse_out, .busy, .done
  );

endmodule

`default_nettype wire

// ==== testbench/pulse_seq_properties.sv ====
`default_nettype none

module pulse_seq_properties
(
  input logic aclk,
  input logic aresetn,
  input logic s_axi_awready,
  input logic s_axi_bvalid,
  input logic s_axi_bready,
  input logic busy,
  input logic done
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  function automatic void flag_failure(input string what);
    $error("%s", what);
    failures++;
  endfunction

  a_resp_after_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_awready |=> s_axi_bvalid)
    else flag_failure("bvalid did not follow awready");

  a_resp_held: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else flag_failure("bvalid fell before bready");

  // A run always ends from the busy state
  a_done_from_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    done |-> $past(busy))
    else flag_failure("done pulsed without busy on the cycle before");

  a_idle_after_reset: assert property (@(posedge aclk)
    !aresetn |=> !busy && !done)
    else flag_failure("busy or done high after reset");

endmodule

bind pulse_seq_top pulse_seq_properties u_pulse_seq_properties (
  .aclk, .aresetn, .s_axi_awready, .s_axi_bvalid, .s_axi_bready, .busy, .done
);

`default_nettype wire

// ==== testbench/seq_checker.sv ====
`default_nettype none

module seq_checker
  import pulse_seq_pkg::*;
#(
  parameter int PROG_DEPTH = 64
)
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 start,
  input  logic [OUT_WIDTH-1:0] pulse_out,
  input  logic                 busy,
  input  logic                 done,
  input  logic                 awready,
  input  logic                 wready,
  input  logic                 bvalid,
  input  logic                 bready,
  input  logic [1:0]           bresp,
  input  logic [31:0]          prog [PROG_DEPTH],
  input  int                   tb_errors,
  input  int                   assert_errors,
  input  logic                 run_end,
  output int                   total_errors,
  output logic                 reported
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [OUT_WIDTH-1:0] exp_value [$];  // Expected changes of pulse_out
  int                   exp_cycle [$];  // Run cycle of each change
  logic [OUT_WIDTH-1:0] exp_final;
  logic [OUT_WIDTH-1:0] last_out;
  int                   exp_done_cycle;
  int                   cycle;
  int                   mismatches = 0;
  int                   other_errors = 0;
  int                   aw_count = 0;
  int                   b_count = 0;
  logic                 in_run = 1'b0;
  logic                 after_reset;

  // Walks the program from word 0, two cycles per command plus WAIT counts
  function automatic int interpret(input logic [OUT_WIDTH-1:0] first_out);
    logic [OUT_WIDTH-1:0] cur;
    logic [OUT_WIDTH-1:0] merged;
    logic [31:0]          word;
    int                   t;
    cur = first_out;
    t = 0;
    exp_value.delete();
    exp_cycle.delete();
    for (int i = 0; i < PROG_DEPTH; i++)
    begin
      word = prog[i];
      merged = (cur & ~word[15:8]) | (word[7:0] & word[15:8]);
      if (word[31:30] == 2'b00)
      begin
        if (merged != cur)
        begin
          exp_value.push_back(merged);
          exp_cycle.push_back(t + 3);  // Seen one cycle after the apply
        end
        cur = merged;
        t += 2;
      end
      else if (word[31:30] == 2'b01)
        t += 2 + int'(word[29:0]);
      else
      begin
        exp_final = cur;
        return t + 3;
      end
    end
    exp_final = cur;
    return -1;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch %s: got %h expected %h", name, got, want);
    mismatches++;
  endtask

  task automatic report_other(input string what);
    $display("error: %s", what);
    other_errors++;
  endtask

  task automatic check_reset_state();
    if (pulse_out != '0)
      report_mismatch("pulse_out", 32'(pulse_out), 32'h0);
    if (busy || done || bvalid)
      report_other("busy, done or bvalid is high after reset");
  endtask

  task automatic check_axi();
    if (awready)
      aw_count++;
    if (wready != awready)
      report_mismatch("s_axi_wready", 32'(wready), 32'(awready));  // Readies pulse together
    if (bvalid && bready)
      b_count++;
    if (bvalid && bresp != 2'b00)
      report_mismatch("s_axi_bresp", 32'(bresp), 32'h0);
  endtask

  task automatic begin_run();
    last_out       = pulse_out;
    exp_done_cycle = interpret(pulse_out);
    cycle          = 0;
    in_run         = 1'b1;
  endtask

  task automatic track_run();
    cycle++;
    if (pulse_out != last_out)
    begin
      if (exp_value.size() == 0)
        report_other("pulse_out changed after the last expected update");
      else
      begin
        if (pulse_out != exp_value[0])
          report_mismatch("pulse_out", 32'(pulse_out), 32'(exp_value[0]));
        if (cycle != exp_cycle[0])
          report_other($sformatf("pulse_out updated on run cycle %0d instead of %0d",
                                 cycle, exp_cycle[0]));
        void'(exp_value.pop_front());
        void'(exp_cycle.pop_front());
      end
      last_out = pulse_out;
    end
    if (done)
    begin
      if (cycle != exp_done_cycle)
        report_other($sformatf("done pulsed on run cycle %0d instead of %0d",
                               cycle, exp_done_cycle));
      if (busy)
        report_other("busy still high when done pulsed");
      if (pulse_out != exp_final)
        report_mismatch("pulse_out", 32'(pulse_out), 32'(exp_final));
      if (exp_value.size() != 0)
        report_other($sformatf("%0d updates of pulse_out never came", exp_value.size()));
      in_run = 1'b0;
    end
    else if (!busy)
      report_other("busy dropped before done");
    else if (cycle > exp_done_cycle + 8)
    begin
      report_other("done did not follow the STOP command");
      in_run = 1'b0;
    end
  endtask

  task automatic close_report();
    if (in_run)
      report_other("the last program was still running at the end");
    if (aw_count != b_count)
      report_other($sformatf("%0d writes got no response", aw_count - b_count));
    $display("errors: %0d mismatch, %0d other, %0d timeout, %0d assertion",
             mismatches, other_errors, tb_errors, assert_errors);
    total_errors = mismatches + other_errors + tb_errors + assert_errors;
    reported     = 1'b1;
  endtask

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      in_run       = 1'b0;
      after_reset  = 1'b1;
      reported     = 1'b0;
      total_errors = 0;
    end
    else
    begin
      if (after_reset)
        check_reset_state();
      after_reset = 1'b0;
      check_axi();
      if (in_run)
        track_run();
      else if (start)
        begin_run();  // A start during a run is not a new run
      else if (done)
        report_other("done pulsed while no program was running");
      if (run_end && !reported)
        close_report();
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_pulse_seq.sv ====
`default_nettype none

module tb_pulse_seq
  import pulse_seq_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_DEPTH = 64;
  localparam int WAIT_LIMIT = 100;   // Cycles allowed for a handshake
  localparam int RUN_LIMIT  = 2000;  // Cycles allowed for one program

  logic                 aclk;
  logic                 aresetn;
  logic [31:0]          s_axi_awaddr;
  logic                 s_axi_awvalid;
  logic                 s_axi_awready;
  logic [31:0]          s_axi_wdata;
  logic [3:0]           s_axi_wstrb;
  logic                 s_axi_wvalid;
  logic                 s_axi_wready;
  logic [1:0]           s_axi_bresp;
  logic                 s_axi_bvalid;
  logic                 s_axi_bready;
  logic                 start;
  logic [OUT_WIDTH-1:0] pulse_out;
  logic                 busy;
  logic                 done;
  logic [31:0]          prog [PROG_DEPTH];  // Host copy of the program RAM
  int                   timeout_errors;
  logic                 run_end;
  int                   total_errors;
  logic                 reported;

  pulse_seq_top u_pulse_seq_top (
    .aclk, .aresetn,
    .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
    .s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
    .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
    .start, .pulse_out, .busy, .done
  );

  seq_checker #(.PROG_DEPTH(PROG_DEPTH)) u_seq_checker (
    .aclk, .aresetn, .start, .pulse_out, .busy, .done,
    .awready(s_axi_awready), .wready(s_axi_wready),
    .bvalid(s_axi_bvalid), .bready(s_axi_bready),
    .bresp(s_axi_bresp), .prog, .tb_errors(timeout_errors),
    .assert_errors(u_pulse_seq_top.u_pulse_seq_properties.failures),
    .run_end, .total_errors, .reported
  );

  initial
  begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  task automatic next_cycle();
    @(posedge aclk);
    #2;  // Drive and sample away from the edge
  endtask

  task automatic idle_cycles(input int count);
    for (int i = 0; i < count; i++)
      next_cycle();
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s was not seen", what);
    timeout_errors++;
  endtask

  task automatic axi_write(input int index, input logic [31:0] data, input logic [3:0] strb);
    int cycles;
    s_axi_awaddr  = 32'(index << 2);  // Byte address of the word
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    cycles = 0;
    next_cycle();
    while (!s_axi_awready && cycles < WAIT_LIMIT)
    begin
      next_cycle();
      cycles++;
    end
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    if (!s_axi_awready)
      report_timeout("awready for a write beat");
    for (int lane = 0; lane < 4; lane++)
    begin
      if (strb[lane])
        prog[index][lane*8 +: 8] = data[lane*8 +: 8];  // Same byte merge as the RAM
    end
    cycles = 0;
    while (!s_axi_bvalid && cycles < WAIT_LIMIT)
    begin
      next_cycle();
      cycles++;
    end
    if (!s_axi_bvalid)
      report_timeout("bvalid for a write");
    else
    begin
      idle_cycles($urandom_range(0, 2));  // Response is held meanwhile
      s_axi_bready = 1'b1;
      next_cycle();
      s_axi_bready = 1'b0;
    end
  endtask

  // Random OUT and WAIT words, then STOP, then word 0 rebuilt by byte lanes
  task automatic load_program(input int n_cmds);
    logic [31:0] word;
    for (int i = 0; i < n_cmds; i++)
    begin
      if ($urandom_range(0, 1) == 0)
        word = {2'b00, 14'd0, 8'($urandom), 8'($urandom)};  // OUT mask and value
      else
        word = {2'b01, 27'd0, 3'($urandom)};  // WAIT of 0 to 7 cycles
      axi_write(i, word, 4'hF);
    end
    axi_write(n_cmds, {1'b1, 1'($urandom), 30'd0}, 4'hF);  // Either STOP code
    word = prog[0];
    axi_write(0, ~word, 4'hF);
    axi_write(0, {~word[31:8], word[7:0]}, 4'b0001);  // Disabled lanes carry wrong bytes
    axi_write(0, {word[31:8], ~word[7:0]}, 4'b1110);
  endtask

  task automatic run_program();
    int cycles;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    idle_cycles(4);
    start = 1'b1;  // Ignored while the program runs
    next_cycle();
    start = 1'b0;
    cycles = 0;
    while (!done && cycles < RUN_LIMIT)
    begin
      next_cycle();
      cycles++;
    end
    if (!done)
      report_timeout("done at the end of the program");
    idle_cycles(3);
  endtask

  initial
  begin
    int cycles;
    void'($urandom(24));
    aresetn        = 1'b0;
    s_axi_awaddr   = '0;
    s_axi_awvalid  = 1'b0;
    s_axi_wdata    = '0;
    s_axi_wstrb    = '0;
    s_axi_wvalid   = 1'b0;
    s_axi_bready   = 1'b0;
    start          = 1'b0;
    run_end        = 1'b0;
    timeout_errors = 0;
    for (int i = 0; i < PROG_DEPTH; i++)
      prog[i] = '0;
    repeat (8) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    idle_cycles(2);
    load_program(4 + $urandom_range(0, 6));
    run_program();
    load_program(4 + $urandom_range(0, 6));
    run_program();
    run_end = 1'b1;  // Checker prints its counts
    cycles = 0;
    next_cycle();
    while (reported !== 1'b1 && cycles < WAIT_LIMIT)
    begin
      next_cycle();
      cycles++;
    end
    if (reported !== 1'b1)
      $display("timeout: the closing report of the checker was not seen");
    if (reported === 1'b1 && total_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== pulse_seq_top.f ====
logic/pulse_seq_pkg.sv
logic/axi_bram_writer.sv
logic/seq_bram.sv
logic/seq_decoder.sv
logic/seq_executor.sv
logic/seq_output.sv
logic/pulse_seq_top.sv
testbench/pulse_seq_properties.sv
testbench/seq_checker.sv
testbench/tb_pulse_seq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the pulse sequencer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_pulse_seq \
  -f pulse_seq_top.f -o sim_pulse_seq

out=$(./obj_dir/sim_pulse_seq +verilator+error+limit+100) || true
echo "$out"

echo "$out" | grep -q "RESULT: PASS"
